// ==== hw/icache_params.svh ====
/*
  instruction cache geometry, address width and fetch width
  reset value of the replacement LFSR
*/

`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// number of ways per set
`define ICACHE_WAYS 4

// number of sets
`define ICACHE_SETS 16

// bytes in one cache line
`define ICACHE_LINE_BYTES 16

// physical address and fetch word widths
`define ICACHE_PADDR_WIDTH 32
`define ICACHE_FETCH_WIDTH 32

// lfsr must never start at zero
`define ICACHE_LFSR_SEED 8'hA5

`endif

// ==== hw/icache_pkg.sv ====
/*
  cache geometry widths and the typed vectors built from them
  controller state encoding
*/

`default_nettype none

`include "icache_params.svh"

package icache_pkg;

  ////////////////////////////////
  // derived widths
  ////////////////////////////////

  // byte offset inside a line
  localparam int unsigned ICACHE_OFFSET_W = $clog2(`ICACHE_LINE_BYTES);
  // set index bits sit right above the offset
  localparam int unsigned ICACHE_INDEX_W  = $clog2(`ICACHE_SETS);
  // whatever is left of the address is tag
  localparam int unsigned ICACHE_TAG_W    = `ICACHE_PADDR_WIDTH - ICACHE_INDEX_W - ICACHE_OFFSET_W;
  localparam int unsigned ICACHE_WAY_W    = $clog2(`ICACHE_WAYS);
  // fetch words per line, and the bits picking one of them
  localparam int unsigned ICACHE_WORDS_PER_LINE = `ICACHE_LINE_BYTES * 8 / `ICACHE_FETCH_WIDTH;
  localparam int unsigned ICACHE_WORD_SEL_W     = $clog2(ICACHE_WORDS_PER_LINE);

  ////////////////////////////////
  // typed vectors
  ////////////////////////////////

  typedef logic [`ICACHE_PADDR_WIDTH-1:0] paddr_t;
  typedef logic [ICACHE_TAG_W-1:0]        tag_t;
  typedef logic [ICACHE_INDEX_W-1:0]      set_idx_t;
  typedef logic [ICACHE_OFFSET_W-1:0]     line_off_t;
  typedef logic [ICACHE_WAY_W-1:0]        way_idx_t;
  typedef logic [`ICACHE_WAYS-1:0]        way_vec_t;
  typedef logic [`ICACHE_FETCH_WIDTH-1:0] word_t;
  // a line is a packed row of fetch words, word 0 at the low end
  typedef word_t [ICACHE_WORDS_PER_LINE-1:0] line_t;

  // controller states
  typedef enum logic [1:0] {
    FLUSH,
    IDLE,
    READ,
    MISS
  } ctrl_state_e;

endpackage

`default_nettype wire

// ==== hw/icache_bus_pkg.sv ====
/*
  fetch port request and response structs
  memory port request and return structs
*/

`default_nettype none

package icache_bus_pkg;

  ////////////////////////////////
  // fetch side
  ////////////////////////////////

  // requester holds req and paddr until accepted
  typedef struct packed {
    logic              req;
    icache_pkg::paddr_t paddr;
  } fetch_req_t;

  // valid is a one cycle pulse with the word aligned address
  typedef struct packed {
    logic               valid;
    icache_pkg::paddr_t paddr;
    icache_pkg::word_t  data;
  } fetch_rsp_t;

  ////////////////////////////////
  // memory side
  ////////////////////////////////

  // line address when nc is low, word address when nc is high
  typedef struct packed {
    icache_pkg::paddr_t paddr;
    logic               nc;
  } mem_req_t;

  // full line returned in a single beat
  typedef struct packed {
    logic              valid;
    icache_pkg::line_t line;
  } mem_rtrn_t;

endpackage

`default_nettype wire

// ==== hw/icache_ctrl.sv ====
/*
  cache controller with the flush/idle/read/miss state machine
  enable and flush tracking, flush index counter
  request address latch and response word select
*/

`timescale 1ns/10ps
`default_nettype none

`include "icache_params.svh"

module icache_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      flush_i,
  input  logic                      en_i,
  input  icache_bus_pkg::fetch_req_t fetch_req_i,
  output logic                      fetch_ready_o,
  output icache_bus_pkg::fetch_rsp_t fetch_rsp_o,
  output logic                      mem_req_o,
  output icache_bus_pkg::mem_req_t   mem_req_data_o,
  input  logic                      mem_ack_i,
  input  icache_bus_pkg::mem_rtrn_t  mem_rtrn_i,
  output logic                      miss_o,
  output logic                      busy_o,
  input  icache_pkg::way_vec_t       hit_i,
  input  icache_pkg::word_t          rd_word_i,
  input  logic                      all_valid_i,
  output logic                      rd_en_o,
  output logic                      fill_en_o,
  output logic                      flush_en_o,
  output icache_pkg::set_idx_t       index_o,
  output icache_pkg::tag_t           tag_o,
  output logic                      lfsr_step_o
);

  import icache_pkg::*;

  ctrl_state_e state_d, state_q;
  logic        cache_en_d, cache_en_q;
  logic        flush_d, flush_q;
  set_idx_t    flush_cnt_q;
  logic        flush_done;
  logic        accept;
  logic        nc_q;
  paddr_t      paddr_q;
  logic [ICACHE_WORD_SEL_W-1:0] word_sel;

  //////////////////////////////
  // address fields
  //////////////////////////////

  // everything comes from the latched address
  assign tag_o    = paddr_q[`ICACHE_PADDR_WIDTH-1 -: ICACHE_TAG_W];
  assign word_sel = paddr_q[ICACHE_OFFSET_W-1 -: ICACHE_WORD_SEL_W];
  assign accept   = fetch_ready_o & fetch_req_i.req;

  // flush walks the sets, lookup uses the live address, fill the latched one
  assign index_o = flush_en_o ? flush_cnt_q :
                   rd_en_o    ? fetch_req_i.paddr[ICACHE_OFFSET_W +: ICACHE_INDEX_W] :
                                paddr_q[ICACHE_OFFSET_W +: ICACHE_INDEX_W];

  // word address for nc, line address otherwise
  assign mem_req_data_o.nc    = nc_q;
  assign mem_req_data_o.paddr = nc_q ? paddr_q :
                                {paddr_q[`ICACHE_PADDR_WIDTH-1:ICACHE_OFFSET_W],
                                 {ICACHE_OFFSET_W{1'b0}}};

  assign fetch_rsp_o.paddr = paddr_q;
  // hits read the arrays, everything else the returned line
  assign fetch_rsp_o.data  = (state_q == MISS) ? mem_rtrn_i.line[word_sel] : rd_word_i;

  assign busy_o      = (state_q != IDLE);
  assign flush_done  = (flush_cnt_q == set_idx_t'(`ICACHE_SETS - 1));
  // random replacement only moves when it was actually used
  assign lfsr_step_o = fill_en_o & all_valid_i;

  //////////////////////////////
  // state machine
  //////////////////////////////

  always_comb begin
    state_d    = state_q;
    // turning off is immediate, turning on goes through a flush
    cache_en_d = cache_en_q & en_i;
    flush_d    = flush_q | flush_i;

    flush_en_o        = 1'b0;
    rd_en_o           = 1'b0;
    fill_en_o         = 1'b0;
    fetch_ready_o     = 1'b0;
    fetch_rsp_o.valid = 1'b0;
    mem_req_o         = 1'b0;
    miss_o            = 1'b0;

    unique case (state_q)
      FLUSH: begin
        flush_en_o = 1'b1;
        if (flush_done) begin
          state_d    = IDLE;
          flush_d    = 1'b0;
          cache_en_d = en_i;
        end
      end
      IDLE: begin
        if (flush_d || (en_i && !cache_en_q)) begin
          state_d = FLUSH;
        end else if (fetch_req_i.req) begin
          // ready is only offered against a waiting request
          fetch_ready_o = 1'b1;
          rd_en_o       = 1'b1;
          state_d       = READ;
        end
      end
      READ: begin
        if (!nc_q && |hit_i) begin
          fetch_rsp_o.valid = 1'b1;
          state_d           = IDLE;
          // back to back hits
          if (!flush_d && fetch_req_i.req) begin
            fetch_ready_o = 1'b1;
            rd_en_o       = 1'b1;
            state_d       = READ;
          end
        end else begin
          // miss or nc, hold the request until memory takes it
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = ~nc_q;
            state_d = MISS;
          end
        end
      end
      MISS: begin
        if (mem_rtrn_i.valid) begin
          fetch_rsp_o.valid = 1'b1;
          // nc data is never allocated
          fill_en_o         = ~nc_q;
          state_d           = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  //////////////////////////////
  // registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      cache_en_q  <= 1'b0;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
      nc_q        <= 1'b0;
    end else begin
      state_q    <= state_d;
      cache_en_q <= cache_en_d;
      flush_q    <= flush_d;
      // counter wraps to zero on the last set
      if (flush_en_o) begin
        flush_cnt_q <= flush_cnt_q + 1'b1;
      end
      // io half or disabled cache goes around the arrays
      if (accept) begin
        nc_q <= fetch_req_i.paddr[`ICACHE_PADDR_WIDTH-1] | ~cache_en_q;
      end
    end
  end

  // low two bits dropped on capture
  always_ff @(posedge clk_i) begin
    if (accept) begin
      paddr_q <= {fetch_req_i.paddr[`ICACHE_PADDR_WIDTH-1:2], 2'b00};
    end
  end

  //////////////////////////////
  // assertions
  //////////////////////////////

  mem_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_req_data_o))
    else $error("icache: memory request dropped or changed before ack");

  legal_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {FLUSH, IDLE, READ, MISS})
    else $error("icache: controller in an illegal state");

endmodule

`default_nettype wire

// ==== hw/icache_arrays.sv ====
/*
  per way tag, valid and data storage with synchronous read
  tag compare, hit vector and word select
  latch of the replacement way used by the next fill
*/

`timescale 1ns/10ps
`default_nettype none

`include "icache_params.svh"

module icache_arrays (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 rd_en_i,
  input  logic                 fill_en_i,
  input  logic                 flush_en_i,
  input  icache_pkg::set_idx_t  index_i,
  input  icache_pkg::tag_t      tag_i,
  input  icache_pkg::line_off_t offset_i,
  input  icache_pkg::way_vec_t  fill_way_i,
  input  icache_pkg::line_t     fill_line_i,
  output icache_pkg::way_vec_t  hit_o,
  output icache_pkg::word_t     rd_word_o,
  output icache_pkg::way_vec_t  valid_o
);

  import icache_pkg::*;

  // storage
  tag_t                       tag_mem  [`ICACHE_WAYS][`ICACHE_SETS];
  line_t                      data_mem [`ICACHE_WAYS][`ICACHE_SETS];
  way_vec_t [`ICACHE_SETS-1:0] valid_q;

  // read port registers
  tag_t      tag_rd_q  [`ICACHE_WAYS];
  line_t     data_rd_q [`ICACHE_WAYS];
  way_vec_t  valid_rd_q;
  line_off_t off_q;
  logic      rd_q;
  way_vec_t  fill_way_q;
  logic [ICACHE_WORD_SEL_W-1:0] word_sel;

  //////////////////////////////
  // write side
  //////////////////////////////

  // fill and flush share the valid bits
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (flush_en_i) begin
      valid_q[index_i] <= '0;
    end else if (fill_en_i) begin
      valid_q[index_i] <= valid_q[index_i] | fill_way_q;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (fill_en_i && fill_way_q[w]) begin
        tag_mem[w][index_i]  <= tag_i;
        data_mem[w][index_i] <= fill_line_i;
      end
    end
  end

  //////////////////////////////
  // read side
  //////////////////////////////

  // whole set read out, word chosen one cycle later
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        tag_rd_q[w]  <= tag_mem[w][index_i];
        data_rd_q[w] <= data_mem[w][index_i];
      end
      off_q <= offset_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_rd_q <= '0;
      rd_q       <= 1'b0;
      fill_way_q <= '0;
    end else begin
      rd_q <= rd_en_i;
      if (rd_en_i) begin
        valid_rd_q <= valid_q[index_i];
      end
      // victim picked while the lookup result is fresh
      if (rd_q) begin
        fill_way_q <= fill_way_i;
      end
    end
  end

  assign valid_o  = valid_rd_q;
  assign word_sel = off_q[ICACHE_OFFSET_W-1 -: ICACHE_WORD_SEL_W];

  // compare against the latched tag
  always_comb begin
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      hit_o[w] = valid_rd_q[w] & (tag_rd_q[w] == tag_i);
    end
  end

  // and-or mux, hit is at most one hot
  always_comb begin
    rd_word_o = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (hit_o[w]) begin
        rd_word_o = rd_word_o | data_rd_q[w][word_sel];
      end
    end
  end

  //////////////////////////////
  // assertions
  //////////////////////////////

  no_fill_on_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(fill_en_i && flush_en_i))
    else $error("icache: fill and flush in the same cycle");

  hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_en_i |=> $onehot0(hit_o))
    else $error("icache: line resident in more than one way");

endmodule

`default_nettype wire

// ==== hw/icache_repl.sv ====
/*
  replacement way choice
  first invalid way, else a way from an 8 bit galois LFSR
*/

`timescale 1ns/10ps
`default_nettype none

`include "icache_params.svh"

module icache_repl (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  icache_pkg::way_vec_t valid_i,
  input  logic                step_i,
  output icache_pkg::way_vec_t way_oh_o,
  output logic                all_valid_o
);

  import icache_pkg::*;

  logic [7:0] lfsr_q;
  way_idx_t   rnd_way;
  way_vec_t   inv_oh;

  // x^8 + x^6 + x^5 + x^4 + 1, shifting right
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= `ICACHE_LFSR_SEED;
    end else if (step_i) begin
      lfsr_q <= {1'b0, lfsr_q[7:1]} ^ (lfsr_q[0] ? 8'hB8 : 8'h00);
    end
  end

  assign rnd_way = lfsr_q[ICACHE_WAY_W-1:0];

  // lowest set bit of the invalid mask
  assign inv_oh      = ~valid_i & (valid_i + 1'b1);
  assign all_valid_o = &valid_i;

  assign way_oh_o = all_valid_o ? (way_vec_t'(1) << rnd_way) : inv_oh;

endmodule

`default_nettype wire

// ==== hw/icache_top.sv ====
/*
  instruction cache top level
  controller, storage arrays and replacement logic
*/

`timescale 1ns/10ps
`default_nettype none

module icache_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      flush_i,
  input  logic                      en_i,
  input  icache_bus_pkg::fetch_req_t fetch_req_i,
  output logic                      fetch_ready_o,
  output icache_bus_pkg::fetch_rsp_t fetch_rsp_o,
  output logic                      mem_req_o,
  output icache_bus_pkg::mem_req_t   mem_req_data_o,
  input  logic                      mem_ack_i,
  input  icache_bus_pkg::mem_rtrn_t  mem_rtrn_i,
  output logic                      miss_o,
  output logic                      busy_o
);

  import icache_pkg::*;

  // controller to arrays
  logic     rd_en;
  logic     fill_en;
  logic     flush_en;
  set_idx_t index;
  tag_t     tag;
  // arrays back to controller and replacement
  way_vec_t hit;
  word_t    rd_word;
  way_vec_t valid;
  // replacement
  way_vec_t repl_way_oh;
  logic     all_valid;
  logic     lfsr_step;

  icache_ctrl i_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .en_i           (en_i),
    .fetch_req_i    (fetch_req_i),
    .fetch_ready_o  (fetch_ready_o),
    .fetch_rsp_o    (fetch_rsp_o),
    .mem_req_o      (mem_req_o),
    .mem_req_data_o (mem_req_data_o),
    .mem_ack_i      (mem_ack_i),
    .mem_rtrn_i     (mem_rtrn_i),
    .miss_o         (miss_o),
    .busy_o         (busy_o),
    .hit_i          (hit),
    .rd_word_i      (rd_word),
    .all_valid_i    (all_valid),
    .rd_en_o        (rd_en),
    .fill_en_o      (fill_en),
    .flush_en_o     (flush_en),
    .index_o        (index),
    .tag_o          (tag),
    .lfsr_step_o    (lfsr_step)
  );

  // offset is captured inside the arrays with the lookup
  icache_arrays i_arrays (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_en_i     (rd_en),
    .fill_en_i   (fill_en),
    .flush_en_i  (flush_en),
    .index_i     (index),
    .tag_i       (tag),
    .offset_i    (fetch_req_i.paddr[ICACHE_OFFSET_W-1:0]),
    .fill_way_i  (repl_way_oh),
    .fill_line_i (mem_rtrn_i.line),
    .hit_o       (hit),
    .rd_word_o   (rd_word),
    .valid_o     (valid)
  );

  icache_repl i_repl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .valid_i     (valid),
    .step_i      (lfsr_step),
    .way_oh_o    (repl_way_oh),
    .all_valid_o (all_valid)
  );

endmodule

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
/*
  testbench clock and reset generator
  20 ns clock, active low reset held for 10 cycles
*/

`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // release just after an edge so the DUT sees a clean first cycle
  initial begin
    rst_no = 1'b0;
    repeat (10) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// ==== dv/icache_tb.sv ====
/*
  instruction cache testbench with memory model and resident line model
  random fetches from a fixed LFSR seed, random ack and return delays
  compare tasks, cycle timeout and final report
*/

`timescale 1ns/10ps
`default_nettype none

`include "icache_params.svh"

module icache_tb;

  import icache_pkg::*;
  import icache_bus_pkg::*;

  localparam int unsigned NUM_REQ = 204;
  localparam int unsigned NUM_FLUSH = 3;
  localparam int unsigned TIMEOUT_CYCLES = NUM_REQ * 12 + NUM_FLUSH * (`ICACHE_SETS + 4) + 40;

  logic clk, rst_n, flush, en, mem_ack, miss, busy, fetch_ready, mem_req;
  fetch_req_t fetch_req;
  fetch_rsp_t fetch_rsp;
  mem_req_t   mem_req_data;
  mem_rtrn_t  mem_rtrn;

  // bookkeeping
  logic [31:0] lfsr_s;
  int          errors, checks, cycles, n_req, rsp_seen, miss_seen, miss_exp;
  logic        en_model;
  bit          resident [paddr_t];
  bit          seen [paddr_t];
  int          tag_cnt [`ICACHE_SETS];
  paddr_t      hot [8];

  tb_clk_gen i_clk_gen (.clk_o(clk), .rst_no(rst_n));

  icache_top uut (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .flush_i        (flush),
    .en_i           (en),
    .fetch_req_i    (fetch_req),
    .fetch_ready_o  (fetch_ready),
    .fetch_rsp_o    (fetch_rsp),
    .mem_req_o      (mem_req),
    .mem_req_data_o (mem_req_data),
    .mem_ack_i      (mem_ack),
    .mem_rtrn_i     (mem_rtrn),
    .miss_o         (miss),
    .busy_o         (busy)
  );

  //////////////////////////////
  // random bits and models
  //////////////////////////////

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r      = {r[30:0], lfsr_s[0]};
      lfsr_s = (lfsr_s >> 1) ^ (lfsr_s[0] ? 32'h8020_0003 : 32'h0);
    end
    return r;
  endfunction

  // memory content is a fixed scramble of the word address
  function automatic word_t model_word(input paddr_t a);
    return ({a[31:2], 2'b00} * 32'h9e37_79b1) ^ 32'h5a5a_1234;
  endfunction

  function automatic line_t model_line(input paddr_t la);
    line_t l;
    for (int i = 0; i < 4; i++) begin
      l[i] = model_word(la + 32'(4 * i));
    end
    return l;
  endfunction

  // few tags per set so lines are reused, bit 31 picks the io half
  function automatic paddr_t rand_addr();
    logic io, far;
    logic [2:0] t;
    paddr_t a;
    io  = (take_bits(3) == 0);
    far = (take_bits(3) == 0);
    t   = far ? 3'(4 + take_bits(2)) : 3'(take_bits(2));
    a   = 32'h0001_2000 | (32'(t) << 8) | (take_bits(4) << 4) | take_bits(4);
    a[31] = io;
    return a;
  endfunction

  function automatic void clear_model();
    resident.delete();
    seen.delete();
    foreach (tag_cnt[i]) tag_cnt[i] = 0;
  endfunction

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  task automatic check_word(input string name, input word_t exp, input word_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_paddr(input string name, input paddr_t exp, input paddr_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED %s: expected %b actual %b", name, exp, act);
    end
  endtask

  //////////////////////////////
  // stimulus tasks
  //////////////////////////////

  // one fetch from request to response, called and left at posedge + 1 ns
  task automatic fetch_and_check(input paddr_t a);
    paddr_t   wa, la;
    mem_req_t held;
    int       ack_dly, ret_dly;
    logic     exp_nc, exp_hit, known;
    wa      = {a[31:2], 2'b00};
    la      = {a[31:4], 4'h0};
    exp_nc  = a[31] | ~en_model;
    exp_hit = 1'b0;
    known   = 1'b1;
    if (!exp_nc) begin
      if (!seen.exists(la)) begin
        seen[la] = 1'b1;
        tag_cnt[a[7:4]]++;
      end
      // more than four tags in a set may evict, hit or miss is then open
      known   = (tag_cnt[a[7:4]] <= 4);
      exp_hit = resident.exists(la);
    end
    fetch_req.req   = 1'b1;
    fetch_req.paddr = a;
    @(negedge clk);
    while (!fetch_ready) @(negedge clk);
    @(posedge clk);
    #1 fetch_req.req = 1'b0;
    n_req++;
    @(negedge clk);
    if (fetch_rsp.valid) begin
      if (exp_nc || (known && !exp_hit)) begin
        errors++;
        $display("response without memory access for %h, a miss was due", a);
      end
      check_bit("hit_mem_req", 1'b0, mem_req);
      check_bit("hit_miss", 1'b0, miss);
      check_paddr("hit_paddr", wa, fetch_rsp.paddr);
      check_word("hit_data", model_word(wa), fetch_rsp.data);
      @(posedge clk);
      #1;
    end else begin
      if (known && exp_hit) begin
        errors++;
        $display("resident line %h gave no response one cycle after acceptance", la);
      end
      check_bit("mem_req", 1'b1, mem_req);
      check_bit("mem_req_nc", exp_nc, mem_req_data.nc);
      check_paddr("mem_req_paddr", exp_nc ? wa : la, mem_req_data.paddr);
      held    = mem_req_data;
      ack_dly = int'(take_bits(2));
      repeat (ack_dly) begin
        @(negedge clk);
        check_bit("mem_req_hold", 1'b1, mem_req);
        check_paddr("mem_req_stable", held.paddr, mem_req_data.paddr);
        check_bit("mem_req_nc_stable", held.nc, mem_req_data.nc);
        check_bit("miss_early", 1'b0, miss);
      end
      @(posedge clk);
      #1 mem_ack = 1'b1;
      @(negedge clk);
      check_bit("mem_req_at_ack", 1'b1, mem_req);
      check_bit("miss_pulse", ~exp_nc, miss);
      if (!exp_nc) miss_exp++;
      @(posedge clk);
      #1 mem_ack = 1'b0;
      ret_dly = 1 + int'(take_bits(2));
      repeat (ret_dly - 1) begin
        @(posedge clk);
        #1;
      end
      mem_rtrn.valid = 1'b1;
      mem_rtrn.line  = model_line(la);
      @(negedge clk);
      check_bit("miss_rsp_valid", 1'b1, fetch_rsp.valid);
      check_paddr("miss_paddr", wa, fetch_rsp.paddr);
      check_word("miss_data", model_word(wa), fetch_rsp.data);
      @(posedge clk);
      #1 mem_rtrn.valid = 1'b0;
      if (!exp_nc) resident[la] = 1'b1;
    end
  endtask

  // kind 0 pulses flush_i, kind 1 raises en_i
  task automatic flush_and_check(input int kind);
    if (kind == 0) flush = 1'b1;
    else en = 1'b1;
    // a waiting fetch must not be taken while the sets are cleared
    fetch_req.req = 1'b1;
    @(posedge clk);
    #1 flush = 1'b0;
    repeat (`ICACHE_SETS) begin
      @(negedge clk);
      check_bit("flush_busy", 1'b1, busy);
      check_bit("flush_ready", 1'b0, fetch_ready);
    end
    @(posedge clk);
    #1 fetch_req.req = 1'b0;
    @(negedge clk);
    check_bit("flush_done", 1'b0, busy);
    @(posedge clk);
    #1;
    en_model = en;
    clear_model();
  endtask

  task automatic report(input string name, input int err_start);
    $display("test %s: %0d errors", name, errors - err_start);
  endtask

  //////////////////////////////
  // monitors and timeout
  //////////////////////////////

  always @(negedge clk) begin
    if (rst_n && fetch_rsp.valid) rsp_seen++;
    if (rst_n && miss) miss_seen++;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("timeout: run went past %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    int e0;
    lfsr_s    = 32'h34f5_f164;
    errors    = 0;
    checks    = 0;
    cycles    = 0;
    n_req     = 0;
    rsp_seen  = 0;
    miss_seen = 0;
    miss_exp  = 0;
    en_model  = 1'b0;
    flush     = 1'b0;
    en        = 1'b0;
    mem_ack   = 1'b0;
    fetch_req = '0;
    mem_rtrn  = '0;
    clear_model();
    @(posedge rst_n);
    @(negedge clk);
    check_bit("reset_busy", 1'b0, busy);
    check_bit("reset_mem_req", 1'b0, mem_req);
    check_bit("reset_ready", 1'b0, fetch_ready);
    @(posedge clk);
    #1;

    // disabled cache goes straight to memory
    e0 = errors;
    repeat (10) fetch_and_check(rand_addr());
    report("disabled_fetch", e0);

    e0 = errors;
    flush_and_check(1);
    report("enable_flush", e0);

    e0 = errors;
    repeat (120) fetch_and_check(rand_addr());
    report("random_fetch", e0);

    // warm a few lines, flush, and they must miss again
    e0 = errors;
    foreach (hot[i]) hot[i] = rand_addr() & 32'h7fff_ffff;
    foreach (hot[i]) fetch_and_check(hot[i]);
    foreach (hot[i]) fetch_and_check(hot[i]);
    flush_and_check(0);
    foreach (hot[i]) fetch_and_check(hot[i]);
    report("flush_refetch", e0);

    e0 = errors;
    en = 1'b0;
    @(posedge clk);
    #1 en_model = 1'b0;
    repeat (10) fetch_and_check(rand_addr());
    flush_and_check(1);
    repeat (40) fetch_and_check(rand_addr());
    report("disable_reenable", e0);

    repeat (3) @(posedge clk);
    check_bit("one_rsp_per_req", 1'b1, rsp_seen == n_req);
    check_bit("miss_count", 1'b1, miss_seen == miss_exp);
    $display("%0d requests, %0d checks, %0d errors", n_req, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+hw
hw/icache_pkg.sv
hw/icache_bus_pkg.sv
hw/icache_ctrl.sv
hw/icache_arrays.sv
hw/icache_repl.sv
hw/icache_top.sv
dv/tb_clk_gen.sv
dv/icache_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile the icache testbench with Verilator, run it, and judge from the log
rm -f sim.log
verilator --binary --timing -Wno-fatal -f all.f --top-module icache_tb -Mdir obj_dir \
  > sim.log 2>&1 &&
./obj_dir/Vicache_tb >> sim.log 2>&1 ||
echo "build or simulation did not complete" >> sim.log
grep -q "^TEST PASSED$" sim.log && exit 0 || exit 1
